/* Makefile */
VERILATOR ?= verilator
TOP       ?= axi_write_iso_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* axi_iso_pkg.sv */
package axi_iso_pkg;

  // AWLEN width in full AXI4, where a burst carries up to 256 beats
  localparam int axi_len_width = 8;

  // OKAY is the only write response the isolator expects to see
  // from the subordinate while it tracks outstanding bursts
  localparam logic [1:0] axi_bresp_okay = 2'b00;

  // isolation sequence as seen from outside the isolator
  //
  // connected passes traffic straight through
  // aligning stops new downstream traffic and evens out AW against W
  // draining waits for every accepted burst to return its B
  // isolated holds the upstream side until the request is withdrawn
  typedef enum logic [1:0] {
    iso_connected = 2'd0,
    iso_aligning  = 2'd1,
    iso_draining  = 2'd2,
    iso_isolated  = 2'd3
  } iso_state_t;

endpackage

/* axi_write_iso.sv */
module axi_write_iso #(
  // AW may lead W, or W lead AW, by this many maximum-length bursts
  parameter int max_transaction_skew = 2,
  // 1 for AXI-Lite, otherwise the full AXI burst length
  parameter int max_burst_len = 2 ** axi_iso_pkg::axi_len_width,
  // bursts that may wait for B at once
  parameter int max_outstanding = 4,
  localparam int len_w = (max_burst_len == 1) ? 1 : $clog2(max_burst_len)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // manager side
  input  logic                    up_awvalid,
  input  logic [len_w-1:0]        up_awlen,
  output logic                    up_awready,
  input  logic                    up_wvalid,
  output logic                    up_wready,
  output logic                    up_bvalid,
  output logic [1:0]              up_bresp,
  input  logic                    up_bready,
  // subordinate side
  output logic                    dn_awvalid,
  output logic [len_w-1:0]        dn_awlen,
  input  logic                    dn_awready,
  output logic                    dn_wvalid,
  input  logic                    dn_wready,
  input  logic                    dn_bvalid,
  input  logic [1:0]              dn_bresp,
  output logic                    dn_bready,
  // isolation control
  input  logic                    isolate_req,
  output logic                    isolated,
  output axi_iso_pkg::iso_state_t iso_state
);

  logic align_req;
  logic align_done;
  logic aw_room;
  logic outstanding_zero;
  logic align_awready;
  logic room_awvalid;

  // AW needs both skew space and response budget. the valid seen by the
  // aligner is qualified the same way, so its counters and the downstream
  // AW only move on a real upstream transfer
  assign up_awready   = align_awready && aw_room;
  assign room_awvalid = up_awvalid && aw_room;
  assign dn_awlen     = up_awlen;

  // responses pass straight back, nothing is buffered on the B channel
  assign up_bvalid = dn_bvalid;
  assign up_bresp  = dn_bresp;
  assign dn_bready = up_bready;

  wdata_align #(
    .max_transaction_skew(max_transaction_skew),
    .max_burst_len       (max_burst_len)
  ) i_wdata_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .up_awvalid(room_awvalid),
    .up_awlen  (up_awlen),
    .up_awready(align_awready),
    .up_wvalid (up_wvalid),
    .up_wready (up_wready),
    .dn_awready(dn_awready),
    .dn_awvalid(dn_awvalid),
    .dn_wready (dn_wready),
    .dn_wvalid (dn_wvalid),
    .align_req (align_req),
    .align_done(align_done)
  );

  bresp_tracker #(
    .max_outstanding(max_outstanding)
  ) i_bresp_tracker (
    .clk             (clk),
    .rst_n           (rst_n),
    .up_awvalid      (up_awvalid),
    .up_awready      (up_awready),
    .dn_bvalid       (dn_bvalid),
    .dn_bready       (dn_bready),
    .dn_bresp        (dn_bresp),
    .aw_room         (aw_room),
    .outstanding_zero(outstanding_zero)
  );

  iso_ctrl i_iso_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .isolate_req     (isolate_req),
    .align_done      (align_done),
    .outstanding_zero(outstanding_zero),
    .align_req       (align_req),
    .isolated        (isolated),
    .iso_state       (iso_state)
  );

endmodule

/* axi_write_iso_tb.sv */
module axi_write_iso_tb;

  // small skew budget so that a leading W channel fills up within a few hundred beats
  localparam int skew         = 1;
  localparam int burst_len    = 256;
  localparam int max_out      = 4;
  localparam int len_w        = axi_iso_pkg::axi_len_width;
  localparam int max_excess   = skew * burst_len;
  // cycles from the last W beat of a burst to its B at the subordinate model
  localparam int b_delay      = 3;
  localparam int stall_cycles = 8;
  localparam int reset_cycles = 10;
  localparam int n_rows       = 28;

  typedef enum logic [2:0] {
    op_aw, op_w, op_burst, op_awstall, op_wstall, op_iso, op_rel, op_idle
  } op_t;

  // full and rand describe the subordinate readies, hold_b also keeps the manager B ready low
  typedef enum logic [1:0] {rdy_full, rdy_rand, rdy_hold_b} mode_t;

  typedef struct packed {
    op_t                     op;
    logic [15:0]             arg;
    mode_t                   mode;
    axi_iso_pkg::iso_state_t exp_state;
  } row_t;

  logic                    clk;
  logic                    rst_n;
  logic                    up_awvalid;
  logic [len_w-1:0]        up_awlen;
  logic                    up_awready;
  logic                    up_wvalid;
  logic                    up_wready;
  logic                    up_bvalid;
  logic [1:0]              up_bresp;
  logic                    up_bready;
  logic                    dn_awvalid;
  logic [len_w-1:0]        dn_awlen;
  logic                    dn_awready;
  logic                    dn_wvalid;
  logic                    dn_wready;
  logic                    dn_bvalid;
  logic [1:0]              dn_bresp;
  logic                    dn_bready;
  logic                    isolate_req;
  logic                    isolated;
  axi_iso_pkg::iso_state_t iso_state;

  // each row is an operation, its AWLEN or beat count, the ready pattern and the
  // state the isolator must be in once the row has settled
  row_t rows [n_rows] = '{
    '{op_aw,      16'd3,   rdy_full,   axi_iso_pkg::iso_connected},
    '{op_w,       16'd4,   rdy_rand,   axi_iso_pkg::iso_connected},
    '{op_w,       16'd4,   rdy_rand,   axi_iso_pkg::iso_connected},
    '{op_aw,      16'd3,   rdy_rand,   axi_iso_pkg::iso_connected},
    '{op_burst,   16'd7,   rdy_rand,   axi_iso_pkg::iso_connected},
    '{op_w,       16'd256, rdy_full,   axi_iso_pkg::iso_connected},
    '{op_wstall,  16'd1,   rdy_full,   axi_iso_pkg::iso_connected},
    '{op_aw,      16'd255, rdy_full,   axi_iso_pkg::iso_connected},
    '{op_aw,      16'd0,   rdy_full,   axi_iso_pkg::iso_connected},
    '{op_idle,    16'd10,  rdy_full,   axi_iso_pkg::iso_connected},
    '{op_burst,   16'd0,   rdy_hold_b, axi_iso_pkg::iso_connected},
    '{op_burst,   16'd0,   rdy_hold_b, axi_iso_pkg::iso_connected},
    '{op_burst,   16'd2,   rdy_hold_b, axi_iso_pkg::iso_connected},
    '{op_burst,   16'd0,   rdy_hold_b, axi_iso_pkg::iso_connected},
    '{op_awstall, 16'd0,   rdy_hold_b, axi_iso_pkg::iso_connected},
    '{op_w,       16'd1,   rdy_full,   axi_iso_pkg::iso_connected},
    '{op_idle,    16'd10,  rdy_full,   axi_iso_pkg::iso_connected},
    '{op_burst,   16'd15,  rdy_full,   axi_iso_pkg::iso_connected},
    '{op_iso,     16'd0,   rdy_full,   axi_iso_pkg::iso_isolated},
    '{op_awstall, 16'd3,   rdy_rand,   axi_iso_pkg::iso_isolated},
    '{op_wstall,  16'd1,   rdy_rand,   axi_iso_pkg::iso_isolated},
    '{op_rel,     16'd0,   rdy_rand,   axi_iso_pkg::iso_connected},
    '{op_w,       16'd3,   rdy_rand,   axi_iso_pkg::iso_connected},
    '{op_burst,   16'd4,   rdy_rand,   axi_iso_pkg::iso_connected},
    '{op_iso,     16'd0,   rdy_rand,   axi_iso_pkg::iso_isolated},
    '{op_rel,     16'd0,   rdy_full,   axi_iso_pkg::iso_connected},
    '{op_burst,   16'd1,   rdy_full,   axi_iso_pkg::iso_connected},
    '{op_idle,    16'd12,  rdy_full,   axi_iso_pkg::iso_connected}
  };

  // manager side, a queue of AWLEN values and the W beats still to send
  int    aw_q [$];
  int    w_todo;
  logic  iso_want;
  mode_t mode;
  // reference counts, balance is positive while AW leads and negative while W leads
  int    balance;
  int    outstanding;
  int    aw_sent;
  int    b_got;
  axi_iso_pkg::iso_state_t exp_state;
  // subordinate model, burst beat counts seen on AW and the W beats not yet matched
  int     dn_len_q [$];
  int     w_credit;
  int     b_due_q [$];
  logic   b_on;
  int     cyc;
  integer seed = 32'h0554_cf4e;

  axi_write_iso #(
    .max_transaction_skew(skew),
    .max_burst_len       (burst_len),
    .max_outstanding     (max_out)
  ) i_axi_write_iso (
    .clk        (clk),
    .rst_n      (rst_n),
    .up_awvalid (up_awvalid),
    .up_awlen   (up_awlen),
    .up_awready (up_awready),
    .up_wvalid  (up_wvalid),
    .up_wready  (up_wready),
    .up_bvalid  (up_bvalid),
    .up_bresp   (up_bresp),
    .up_bready  (up_bready),
    .dn_awvalid (dn_awvalid),
    .dn_awlen   (dn_awlen),
    .dn_awready (dn_awready),
    .dn_wvalid  (dn_wvalid),
    .dn_wready  (dn_wready),
    .dn_bvalid  (dn_bvalid),
    .dn_bresp   (dn_bresp),
    .dn_bready  (dn_bready),
    .isolate_req(isolate_req),
    .isolated   (isolated),
    .iso_state  (iso_state)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s expected %b, got %b", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_state(input string name, input axi_iso_pkg::iso_state_t actual,
                             input axi_iso_pkg::iso_state_t expected);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s expected %s, got %s", $time, name, expected.name(),
               actual.name());
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_len(input string name, input logic [len_w-1:0] actual,
                           input logic [len_w-1:0] expected);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] actual,
                            input logic [1:0] expected);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s expected %b, got %b", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_count(input string name, input int actual, input int expected);
    if (actual != expected) begin
      $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // one clock of manager, subordinate and reference model
  // inputs change 1 unit after the edge and outputs are compared 1 unit later
  task automatic run_cycle();
    logic align_req_m;
    logic align_done_m;
    logic drained_m;
    logic room_m;
    logic aw_full_m;
    logic w_full_m;
    logic exp_awready;
    logic exp_wready;
    logic exp_dn_awvalid;
    logic exp_dn_wvalid;
    logic aw_x;
    logic w_x;
    logic b_x;
    @(posedge clk);
    #1;
    cyc = cyc + 1;
    up_awvalid  = aw_q.size() != 0;
    up_awlen    = (aw_q.size() != 0) ? len_w'(aw_q[0]) : '0;
    up_wvalid   = w_todo != 0;
    up_bready   = mode != rdy_hold_b;
    isolate_req = iso_want;
    if (mode == rdy_rand) begin
      dn_awready = ($random(seed) & 3) != 0;
      dn_wready  = ($random(seed) & 3) != 0;
    end else begin
      dn_awready = 1'b1;
      dn_wready  = 1'b1;
    end
    if (!b_on && b_due_q.size() != 0 && b_due_q[0] <= cyc) begin
      b_on = 1'b1;
    end
    dn_bvalid = b_on;
    // the response code only means something with valid, SLVERR in between
    dn_bresp  = b_on ? axi_iso_pkg::axi_bresp_okay : 2'b10;
    #1;
    // cut off in every state but connected, and once aligned both channels hold
    align_req_m  = exp_state != axi_iso_pkg::iso_connected;
    align_done_m = align_req_m && balance == 0;
    // the controller sees the registered count, before this cycle's handshakes
    drained_m    = outstanding == 0;
    room_m       = outstanding < max_out;
    aw_full_m    = balance > max_excess - burst_len;
    w_full_m     = -balance >= max_excess;
    exp_awready  = dn_awready && room_m && !aw_full_m && !(align_req_m && balance >= 0);
    exp_wready   = dn_wready && !w_full_m && !(align_req_m && balance <= 0);
    exp_dn_awvalid = up_awvalid && room_m && !aw_full_m && !align_req_m;
    exp_dn_wvalid  = up_wvalid && !w_full_m && !align_req_m;
    check_state("iso_state", iso_state, exp_state);
    check_bit("isolated", isolated, exp_state == axi_iso_pkg::iso_isolated);
    check_bit("up_awready", up_awready, exp_awready);
    check_bit("up_wready", up_wready, exp_wready);
    check_bit("dn_awvalid", dn_awvalid, exp_dn_awvalid);
    check_bit("dn_wvalid", dn_wvalid, exp_dn_wvalid);
    check_bit("up_bvalid", up_bvalid, b_on);
    check_bit("dn_bready", dn_bready, up_bready);
    check_resp("up_bresp", up_bresp, dn_bresp);
    if (exp_dn_awvalid) begin
      check_len("dn_awlen", dn_awlen, up_awlen);
    end
    aw_x = up_awvalid && exp_awready;
    w_x  = up_wvalid && exp_wready;
    b_x  = b_on && up_bready;
    // an AW adds its beats to the balance and a W beat takes one away
    if (aw_x) begin
      balance = balance + aw_q[0] + 1;
      void'(aw_q.pop_front());
      aw_sent = aw_sent + 1;
      outstanding = outstanding + 1;
    end
    if (w_x) begin
      balance = balance - 1;
      w_todo  = w_todo - 1;
    end
    if (b_x) begin
      outstanding = outstanding - 1;
      b_got = b_got + 1;
      b_on  = 1'b0;
      void'(b_due_q.pop_front());
    end
    // the subordinate answers each burst once all its beats have arrived
    if (exp_dn_awvalid && dn_awready) begin
      dn_len_q.push_back(int'(dn_awlen) + 1);
    end
    if (exp_dn_wvalid && dn_wready) begin
      w_credit = w_credit + 1;
    end
    while (dn_len_q.size() != 0 && w_credit >= dn_len_q[0]) begin
      w_credit = w_credit - dn_len_q[0];
      void'(dn_len_q.pop_front());
      b_due_q.push_back(cyc + b_delay);
    end
    case (exp_state)
      axi_iso_pkg::iso_connected: if (isolate_req) exp_state = axi_iso_pkg::iso_aligning;
      axi_iso_pkg::iso_aligning:  if (align_done_m) exp_state = axi_iso_pkg::iso_draining;
      axi_iso_pkg::iso_draining: begin
        if (align_done_m && drained_m) exp_state = axi_iso_pkg::iso_isolated;
      end
      default: if (!isolate_req) exp_state = axi_iso_pkg::iso_connected;
    endcase
  endtask

  // ends a run that stops making progress
  initial begin
    #(n_rows * 600 + reset_cycles * 10);
    $display("watchdog expired, the run hung");
    $display("Test failed");
    $fatal(1, "timeout");
  end

  initial begin
    rst_n       = 1'b0;
    up_awvalid  = 1'b0;
    up_awlen    = '0;
    up_wvalid   = 1'b0;
    up_bready   = 1'b1;
    dn_awready  = 1'b1;
    dn_wready   = 1'b1;
    dn_bvalid   = 1'b0;
    dn_bresp    = axi_iso_pkg::axi_bresp_okay;
    isolate_req = 1'b0;
    iso_want    = 1'b0;
    mode        = rdy_full;
    w_todo      = 0;
    balance     = 0;
    outstanding = 0;
    aw_sent     = 0;
    b_got       = 0;
    w_credit    = 0;
    b_on        = 1'b0;
    cyc         = 0;
    exp_state   = axi_iso_pkg::iso_connected;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    #1;
    check_bit("isolated", isolated, 1'b0);
    check_state("iso_state", iso_state, axi_iso_pkg::iso_connected);
    check_bit("dn_awvalid", dn_awvalid, 1'b0);
    check_bit("dn_wvalid", dn_wvalid, 1'b0);
    for (int r = 0; r < n_rows; r++) begin
      mode = rows[r].mode;
      case (rows[r].op)
        op_aw: begin
          aw_q.push_back(int'(rows[r].arg));
          while (aw_q.size() != 0) run_cycle();
        end
        op_w: begin
          w_todo = w_todo + int'(rows[r].arg);
          while (w_todo != 0) run_cycle();
        end
        op_burst: begin
          aw_q.push_back(int'(rows[r].arg));
          w_todo = w_todo + int'(rows[r].arg) + 1;
          while (aw_q.size() != 0 || w_todo != 0) run_cycle();
        end
        // the request stays pending for later rows, as AXI valid must not drop
        op_awstall: begin
          aw_q.push_back(int'(rows[r].arg));
          repeat (stall_cycles) begin
            run_cycle();
            check_bit("up_awready", up_awready, 1'b0);
          end
        end
        op_wstall: begin
          w_todo = w_todo + 1;
          repeat (stall_cycles) begin
            run_cycle();
            check_bit("up_wready", up_wready, 1'b0);
          end
        end
        op_iso: begin
          iso_want = 1'b1;
          while (exp_state != axi_iso_pkg::iso_isolated) run_cycle();
        end
        op_rel: begin
          iso_want = 1'b0;
          while (exp_state != axi_iso_pkg::iso_connected) run_cycle();
        end
        default: repeat (int'(rows[r].arg)) run_cycle();
      endcase
      // one more clock lets the registered state catch up with the model
      run_cycle();
      check_state("iso_state at row end", iso_state, rows[r].exp_state);
    end
    check_count("b responses", b_got, aw_sent);
    check_count("outstanding bursts", outstanding, 0);
    check_count("aw/w balance", balance, 0);
    $display("Test passed");
    $finish;
  end

endmodule

/* bresp_tracker.sv */
module bresp_tracker #(
  // bursts that may be waiting for their B at once
  parameter int max_outstanding = 4,
  localparam int cnt_w = $clog2(max_outstanding + 1)
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       up_awvalid,
  input  logic       up_awready,
  input  logic       dn_bvalid,
  input  logic       dn_bready,
  input  logic [1:0] dn_bresp,
  output logic       aw_room,
  output logic       outstanding_zero
);

  if (max_outstanding < 1) begin : g_bad_outstanding
    $error("max_outstanding must be at least 1");
  end

  logic [cnt_w-1:0] outstanding;
  logic             aw_accept;
  logic             b_accept;

  // a burst is counted when the manager hands it over, not when the
  // subordinate takes it, so every accepted AW owes exactly one B
  assign aw_accept = up_awvalid && up_awready;
  assign b_accept  = dn_bvalid && dn_bready;

  // an AW and a B in the same cycle leave the count unchanged
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      outstanding <= '0;
    end else if (aw_accept && !b_accept) begin
      outstanding <= outstanding + cnt_w'(1);
    end else if (!aw_accept && b_accept) begin
      outstanding <= outstanding - cnt_w'(1);
    end
  end

  // both flags come from the registered count
  // a new AW waits when the response budget is used up
  assign aw_room          = outstanding < cnt_w'(max_outstanding);
  assign outstanding_zero = outstanding == '0;

  // the subordinate never answers a burst that was not handed to it
  no_underflow_a: assert property (@(posedge clk) disable iff (!rst_n)
    b_accept |-> outstanding != '0);

  // the top level joins aw_room into the AW ready, which caps the count
  no_overflow_a: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= cnt_w'(max_outstanding));

  // responses that are counted here come back as OKAY from this subordinate
  bresp_okay_a: assert property (@(posedge clk) disable iff (!rst_n)
    dn_bvalid |-> dn_bresp == axi_iso_pkg::axi_bresp_okay);

endmodule

/* compile.f */
axi_iso_pkg.sv
wdata_align.sv
bresp_tracker.sv
iso_ctrl.sv
axi_write_iso.sv
axi_write_iso_tb.sv

/* iso_ctrl.sv */
module iso_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   isolate_req,
  input  logic                   align_done,
  input  logic                   outstanding_zero,
  output logic                   align_req,
  output logic                   isolated,
  output axi_iso_pkg::iso_state_t iso_state
);

  axi_iso_pkg::iso_state_t state;
  axi_iso_pkg::iso_state_t state_next;

  // the sequence only moves forward, one step per clock at most
  //
  // connected waits for a request. isolate_req is low on every way back
  // into connected, so a high level there is always a fresh request
  //
  // aligning waits until the trackers report AW and W even
  //
  // draining waits until the last accepted burst has its response, and
  // checks alignment again since the trackers hold both channels by then
  //
  // isolated stays put until the request is withdrawn
  always_comb begin
    state_next = state;
    case (state)
      axi_iso_pkg::iso_connected: begin
        if (isolate_req) begin
          state_next = axi_iso_pkg::iso_aligning;
        end
      end
      axi_iso_pkg::iso_aligning: begin
        if (align_done) begin
          state_next = axi_iso_pkg::iso_draining;
        end
      end
      axi_iso_pkg::iso_draining: begin
        if (align_done && outstanding_zero) begin
          state_next = axi_iso_pkg::iso_isolated;
        end
      end
      axi_iso_pkg::iso_isolated: begin
        if (!isolate_req) begin
          state_next = axi_iso_pkg::iso_connected;
        end
      end
      default: begin
        state_next = axi_iso_pkg::iso_connected;
      end
    endcase
  end

  // isolated is registered alongside the state so it rises and falls
  // on the same clock as the move into and out of iso_isolated
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= axi_iso_pkg::iso_connected;
      isolated <= 1'b0;
    end else begin
      state    <= state_next;
      isolated <= state_next == axi_iso_pkg::iso_isolated;
    end
  end

  // the trackers keep the subordinate cut off in every state but connected,
  // so the downstream valids fall one clock after the request rises
  assign align_req = state != axi_iso_pkg::iso_connected;
  assign iso_state = state;

  // a request may only be dropped once the link has been reported isolated
  req_held_a: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(isolate_req) |-> $past(isolated));

  // the hold in wdata_align keeps both channels even for the whole isolated period
  isolated_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
    isolated |-> align_done);

endmodule

/* wdata_align.sv */
module wdata_align #(
  // skew budget in maximum-length bursts, in either direction
  parameter int max_transaction_skew = 2,
  // 1 for AXI-Lite, otherwise the full AXI burst length
  parameter int max_burst_len = 2 ** axi_iso_pkg::axi_len_width,
  localparam int len_w = (max_burst_len == 1) ? 1 : $clog2(max_burst_len)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             up_awvalid,
  input  logic [len_w-1:0] up_awlen,
  output logic             up_awready,
  input  logic             up_wvalid,
  output logic             up_wready,
  input  logic             dn_awready,
  output logic             dn_awvalid,
  input  logic             dn_wready,
  output logic             dn_wvalid,
  input  logic             align_req,
  output logic             align_done
);

  // a burst holds up to max_burst_len beats, so its beat count needs one more bit
  localparam int lenc_w = $clog2(max_burst_len + 1);
  // total beats either channel may run ahead of the other
  localparam int max_excess = max_transaction_skew * max_burst_len;
  localparam int cnt_w = $clog2(max_excess + 1);

  // the burst length must be AXI-Lite or full AXI, and the skew budget nonzero
  if (max_burst_len != 1 && max_burst_len != 2 ** axi_iso_pkg::axi_len_width) begin : g_bad_len
    $error("max_burst_len must be 1 or the full AXI burst length");
  end
  if (max_transaction_skew < 1) begin : g_bad_skew
    $error("max_transaction_skew must be at least 1");
  end

  logic [cnt_w-1:0]  excess_aw;
  logic [cnt_w-1:0]  excess_w;
  logic [cnt_w-1:0]  excess_aw_next;
  logic [cnt_w-1:0]  excess_w_next;
  logic [cnt_w:0]    aw_side;
  logic [cnt_w:0]    w_side;
  logic [lenc_w-1:0] aw_beat_len;
  logic              aw_beat;
  logic              w_beat;
  logic              aw_full;
  logic              w_full;
  logic              aw_leads;
  logic              w_leads;
  logic              hold_aw;
  logic              hold_w;

  // AWLEN counts from zero, an AXI-Lite request is always a single beat
  assign aw_beat_len = (max_burst_len == 1) ? lenc_w'(1) : lenc_w'(up_awlen) + lenc_w'(1);

  // both counters follow the upstream handshakes, whatever happens downstream
  assign aw_beat = up_awvalid && up_awready;
  assign w_beat  = up_wvalid && up_wready;

  // the beats owed by accepted AW and the beats received ahead of their AW
  // cancel each other, so an accepted AW first eats the excess W beats and a
  // W beat first eats the beats an earlier AW still owes
  always_comb begin
    aw_side = {1'b0, excess_aw} + (aw_beat ? (cnt_w + 1)'(aw_beat_len) : '0);
    w_side  = {1'b0, excess_w} + (w_beat ? (cnt_w + 1)'(1) : '0);
    if (aw_side >= w_side) begin
      excess_aw_next = cnt_w'(aw_side - w_side);
      excess_w_next  = '0;
    end else begin
      excess_aw_next = '0;
      excess_w_next  = cnt_w'(w_side - aw_side);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      excess_aw <= '0;
      excess_w  <= '0;
    end else begin
      excess_aw <= excess_aw_next;
      excess_w  <= excess_w_next;
    end
  end

  // AW stops once the counter could not absorb another maximum-length burst
  assign aw_full = excess_aw > cnt_w'(max_excess - max_burst_len);
  // W stops once the counter could not absorb one more beat
  assign w_full  = excess_w >= cnt_w'(max_excess);

  // at most one count is nonzero, and that one names the leading channel
  assign aw_leads = excess_aw != '0;
  assign w_leads  = excess_w != '0;

  // while aligning only the lagging channel may move
  // once both counts reach zero, neither may
  assign hold_aw = align_req && !w_leads;
  assign hold_w  = align_req && !aw_leads;

  assign up_awready = dn_awready && !aw_full && !hold_aw;
  assign up_wready  = dn_wready && !w_full && !hold_w;

  // a downstream transfer only happens when the upstream one does, and the
  // subordinate sees nothing new once alignment has been requested
  assign dn_awvalid = up_awvalid && !aw_full && !align_req;
  assign dn_wvalid  = up_wvalid && !w_full && !align_req;

  assign align_done = align_req && !aw_leads && !w_leads;

  awlen_legal_a: assert property (@(posedge clk) disable iff (!rst_n)
    up_awvalid |-> int'(up_awlen) < max_burst_len);

endmodule
